// File: build.sh
#!/usr/bin/env bash
# Compile and run the colour mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=colmix_tb
LOG=sim.log

verilator --binary --assert -f colmix.f --top-module "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

// File: colmix.f
src/colmix_pkg.sv
src/pal_ram.sv
src/pal_decode.sv
src/shade_exec.sv
src/blank_result.sv
src/colmix_top.sv
verification/colmix_props.sv
verification/colmix_tb.sv

// File: src/blank_result.sv
/*
 * Result stage
 * Delays the early blanking signals to match the colour pipeline
 * and registers the final colour, black during blanking.
 */

module blank_result (
    input  logic             clk,
    input  logic             rst,
    input  logic             pxl_cen,   // Pixel clock enable
    input  logic             pre_lhbl,  // Early horizontal blank, low active
    input  logic             pre_lvbl,  // Early vertical blank, low active
    input  colmix_pkg::rgb_t color,
    output logic             lhbl,
    output logic             lvbl,
    output colmix_pkg::chan_t red,
    output colmix_pkg::chan_t green,
    output colmix_pkg::chan_t blue
);

    localparam int TAP = colmix_pkg::PIPE_DLY - 1;  // Oldest shift entry

    logic [colmix_pkg::PIPE_DLY-1:0] hb_sr;  // Horizontal blank delay line
    logic [colmix_pkg::PIPE_DLY-1:0] vb_sr;  // Vertical blank delay line
    logic                            lhbl_q;
    logic                            lvbl_q;
    logic                            show;   // Active display for this pixel
    colmix_pkg::rgb_t                rgb_q;

    // Blank state of the pixel now leaving the execute stage
    assign show = hb_sr[TAP] & vb_sr[TAP];

    always_ff @(posedge clk) begin
        if (rst) begin
            hb_sr  <= '0;  // Blanking active out of reset
            vb_sr  <= '0;
            lhbl_q <= 1'b0;
            lvbl_q <= 1'b0;
            rgb_q  <= '0;
        end else if (pxl_cen) begin
            hb_sr  <= {hb_sr[TAP-1:0], pre_lhbl};
            vb_sr  <= {vb_sr[TAP-1:0], pre_lvbl};
            lhbl_q <= hb_sr[TAP];  // Same strobe as its colour
            lvbl_q <= vb_sr[TAP];
            rgb_q  <= show ? color : '0;  // Black outside active area
        end
    end

    assign lhbl  = lhbl_q;
    assign lvbl  = lvbl_q;
    assign red   = rgb_q.red;
    assign green = rgb_q.green;
    assign blue  = rgb_q.blue;

endmodule

// File: src/colmix_pkg.sv
/*
 * Colour mixer shared definitions
 * Widths, palette word layout, colour structs and pipeline depth
 * for the palette lookup and shadow pipeline.
 */

package colmix_pkg;

    // Basic widths
    localparam int CHAN_W    = 5;   // Bits per colour channel
    localparam int PAL_AW    = 11;  // Palette index width
    localparam int CPU_AW    = 13;  // CPU word address into palette window
    localparam int WORD_W    = 16;  // Palette word width
    localparam int PAL_DEPTH = 1 << PAL_AW;  // 2K entries

    // Strobes from request sample to colour at the outputs
    localparam int PIPE_DLY  = 2;

    typedef logic [CHAN_W-1:0] chan_t;      // One colour channel
    typedef logic [PAL_AW-1:0] pal_addr_t;  // Palette index
    typedef logic [CPU_AW-1:0] cpu_addr_t;  // Upper bits only mirror
    typedef logic [WORD_W-1:0] pal_word_t;  // Raw word as stored in RAM

    // Unpacked colour, red in the top bits
    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    // Decoded palette entry
    typedef struct packed {
        logic immune;   // Word bit 15, ignores shadow
        rgb_t color;
    } pal_entry_t;

    // One pixel request from the tile map side
    typedef struct packed {
        pal_addr_t addr;      // Palette index
        logic      shadow;    // Dim this pixel
        logic      video_en;  // Low forces black
    } pxl_req_t;

endpackage

// File: src/colmix_top.sv
/*
 * Colour mixer top level
 * CPU palette port, palette RAM and the decode, shade and
 * blank stages of the pixel colour pipeline.
 */

module colmix_top (
    input  logic                  rst,
    input  logic                  clk,
    input  logic                  pxl_cen,   // Pixel clock enable

    input  logic                  video_en,
    input  logic                  pre_lhbl,
    input  logic                  pre_lvbl,

    // CPU side
    input  logic                  pal_cs,
    input  colmix_pkg::cpu_addr_t cpu_addr,
    input  colmix_pkg::pal_word_t cpu_dout,
    input  logic [1:0]            dswn,      // Byte strobes, low active
    output colmix_pkg::pal_word_t cpu_din,

    // From tile map generator
    input  colmix_pkg::pal_addr_t pal_addr,
    input  logic                  shadow,

    output colmix_pkg::chan_t     red,
    output colmix_pkg::chan_t     green,
    output colmix_pkg::chan_t     blue,
    output logic                  lvbl,
    output logic                  lhbl
);

    logic [1:0]             cpu_we;        // Per-byte write enable
    colmix_pkg::pxl_req_t   req;           // Incoming pixel
    colmix_pkg::pal_addr_t  vid_addr;
    colmix_pkg::pal_word_t  vid_data;
    colmix_pkg::pal_entry_t dec_entry;     // Decode to execute
    logic                   dec_shadow;
    logic                   dec_video_en;
    colmix_pkg::rgb_t       exe_color;     // Execute to result

    assign cpu_we = ~dswn & {2{pal_cs}};  // Only while selected

    assign req.addr     = pal_addr;
    assign req.shadow   = shadow;
    assign req.video_en = video_en;

    pal_ram u_ram (
        .clk       (clk),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_dout),
        .cpu_rdata (cpu_din),
        .vid_addr  (vid_addr),
        .vid_data  (vid_data)
    );

    pal_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .req      (req),
        .vid_addr (vid_addr),
        .vid_data (vid_data),
        .entry    (dec_entry),
        .shadow   (dec_shadow),
        .video_en (dec_video_en)
    );

    shade_exec u_exec (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .entry    (dec_entry),
        .shadow   (dec_shadow),
        .video_en (dec_video_en),
        .color    (exe_color)
    );

    blank_result u_result (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pre_lhbl (pre_lhbl),
        .pre_lvbl (pre_lvbl),
        .color    (exe_color),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

endmodule

// File: src/pal_decode.sv
/*
 * Decode stage
 * Registers the pixel request on each strobe, drives the palette
 * address and unpacks the returned word into 5-bit channels.
 */

module pal_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,   // Pixel clock enable
    input  colmix_pkg::pxl_req_t   req,
    output colmix_pkg::pal_addr_t  vid_addr,
    input  colmix_pkg::pal_word_t  vid_data,
    output colmix_pkg::pal_entry_t entry,
    output logic                   shadow,
    output logic                   video_en
);

    colmix_pkg::pxl_req_t req_q;  // Request held for one pixel

    // Word layout:
    //   [15]    shadow immune
    //   [14:12] blue, green, red LSBs
    //   [11:8]  blue MSBs
    //   [7:4]   green MSBs
    //   [3:0]   red MSBs
    function automatic colmix_pkg::pal_entry_t unpack(input colmix_pkg::pal_word_t w);
        colmix_pkg::pal_entry_t e;
        e.immune      = w[15];
        e.color.red   = {w[3:0], w[12]};   // LSB from bit 12
        e.color.green = {w[7:4], w[13]};   // LSB from bit 13
        e.color.blue  = {w[11:8], w[14]};  // LSB from bit 14
        return e;
    endfunction

    // Sample index and flags together so they stay with the same pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;
        end else if (pxl_cen) begin
            req_q <= req;
        end
    end

    assign vid_addr = req_q.addr;        // To palette RAM video port
    assign entry    = unpack(vid_data);  // RAM word already registered
    assign shadow   = req_q.shadow;
    assign video_en = req_q.video_en;

endmodule

// File: src/pal_ram.sv
/*
 * Palette RAM, 2K x 16
 * CPU port with byte write enables and registered read back,
 * read-only video port reading on every clock.
 */

module pal_ram (
    input  logic                  clk,
    input  logic [1:0]            cpu_we,     // Bit 1 high byte, bit 0 low byte
    input  colmix_pkg::cpu_addr_t cpu_addr,
    input  colmix_pkg::pal_word_t cpu_wdata,
    output colmix_pkg::pal_word_t cpu_rdata,
    input  colmix_pkg::pal_addr_t vid_addr,
    output colmix_pkg::pal_word_t vid_data
);

    colmix_pkg::pal_word_t mem [colmix_pkg::PAL_DEPTH];  // Palette storage

    colmix_pkg::pal_addr_t cpu_idx;  // Folded CPU address

    // Upper CPU address bits only select mirrors
    assign cpu_idx = cpu_addr[colmix_pkg::PAL_AW-1:0];

    // CPU side
    always_ff @(posedge clk) begin
        if (cpu_we[0]) begin
            mem[cpu_idx][7:0]  <= cpu_wdata[7:0];   // Low byte
        end
        if (cpu_we[1]) begin
            mem[cpu_idx][15:8] <= cpu_wdata[15:8];  // High byte
        end
        // Old contents on a same-cycle write
        cpu_rdata <= mem[cpu_idx];
    end

    // Video side, one clock latency
    // The pixel enable is never high on two clocks in a row,
    // so the word is ready well before the next strobe
    always_ff @(posedge clk) begin
        vid_data <= mem[vid_addr];
    end

endmodule

// File: src/shade_exec.sv
/*
 * Execute stage
 * Applies shadow dimming to three quarters on non-immune entries
 * and blacks the pixel when video is disabled.
 */

module shade_exec (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,   // Pixel clock enable
    input  colmix_pkg::pal_entry_t entry,
    input  logic                   shadow,
    input  logic                   video_en,
    output colmix_pkg::rgb_t       color
);

    colmix_pkg::rgb_t gated;    // Colour after shadow and enable
    colmix_pkg::rgb_t color_q;
    logic             dim_en;   // Shadow applies to this pixel

    // a - a/4, never wraps since a/4 <= a
    function automatic colmix_pkg::chan_t dim(input colmix_pkg::chan_t a);
        colmix_pkg::chan_t q;
        q = a >> 2;
        return a - q;
    endfunction

    assign dim_en = shadow & ~entry.immune;  // Bit 15 set ignores shadow

    always_comb begin
        if (dim_en) begin
            gated.red   = dim(entry.color.red);
            gated.green = dim(entry.color.green);
            gated.blue  = dim(entry.color.blue);
        end else begin
            gated = entry.color;
        end
        // Video disable wins over everything
        if (!video_en) begin
            gated = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            color_q <= '0;
        end else if (pxl_cen) begin
            color_q <= gated;
        end
    end

    assign color = color_q;

endmodule

// File: verification/colmix_props.sv
/*
 * Colour mixer properties
 * Blanked and reset outputs stay black, CPU writes need the chip select.
 */

module colmix_props (
    input logic              clk,
    input logic              rst,
    input logic              pal_cs,
    input logic [1:0]        cpu_we,
    input colmix_pkg::chan_t red,
    input colmix_pkg::chan_t green,
    input colmix_pkg::chan_t blue,
    input logic              lhbl,
    input logic              lvbl
);

    // Any blank forces black
    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        (!lhbl || !lvbl) |-> (red == '0 && green == '0 && blue == '0))
        else $error("colour output not black during blanking");

    // One edge of reset clears every output
    a_reset_zero: assert property (@(posedge clk)
        rst |=> (red == '0 && green == '0 && blue == '0 && !lhbl && !lvbl))
        else $error("outputs not cleared by reset");

    a_we_needs_cs: assert property (@(posedge clk)
        !pal_cs |-> (cpu_we == 2'b00))
        else $error("palette write enable active without chip select");

endmodule

bind colmix_top colmix_props u_props (
    .clk    (clk),
    .rst    (rst),
    .pal_cs (pal_cs),
    .cpu_we (cpu_we),   // Internal to the top level
    .red    (red),
    .green  (green),
    .blue   (blue),
    .lhbl   (lhbl),
    .lvbl   (lvbl)
);

// File: verification/colmix_tb.sv
/*
 * Colour mixer testbench
 * Directed tests of the CPU palette port and the pixel pipeline,
 * checked against a palette model and the unpack, shadow and blank rules.
 */

module colmix_tb;

    logic                  clk = 1'b0;
    logic                  pxl_cen = 1'b0;
    logic                  cen_cnt = 1'b0;  // Pixel enable divider
    logic                  rst;
    logic                  video_en;
    logic                  pre_lhbl;
    logic                  pre_lvbl;
    logic                  pal_cs;
    colmix_pkg::cpu_addr_t cpu_addr;
    colmix_pkg::pal_word_t cpu_dout;
    logic [1:0]            dswn;
    colmix_pkg::pal_word_t cpu_din;
    colmix_pkg::pal_addr_t pal_addr;
    logic                  shadow;
    colmix_pkg::chan_t     red;
    colmix_pkg::chan_t     green;
    colmix_pkg::chan_t     blue;
    logic                  lvbl;
    logic                  lhbl;

    colmix_pkg::pal_word_t pal_model [colmix_pkg::PAL_DEPTH];  // Copy of every CPU write
    colmix_pkg::pal_addr_t pix_addr [16];   // Entries for the video tests
    logic [17:0]           exp_q [$];       // Check flag, then {lhbl, lvbl, r, g, b}
    int                    seed = 32'hf6292617;

    colmix_top dut0 (
        .rst      (rst),
        .clk      (clk),
        .pxl_cen  (pxl_cen),
        .video_en (video_en),
        .pre_lhbl (pre_lhbl),
        .pre_lvbl (pre_lvbl),
        .pal_cs   (pal_cs),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .dswn     (dswn),
        .cpu_din  (cpu_din),
        .pal_addr (pal_addr),
        .shadow   (shadow),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lvbl     (lvbl),
        .lhbl     (lhbl)
    );

    always #10 clk = ~clk;  // 20 unit period

    // Strobe on every second clock
    always @(posedge clk) begin
        cen_cnt <= cen_cnt + 1'b1;
        pxl_cen <= cen_cnt;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, why);
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERR %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // Next rising edge where the DUT sees pxl_cen at the given level
    task automatic wait_cen(input logic level);
        int n;
        n = 0;
        @(posedge clk);
        while (pxl_cen !== level) begin
            n = n + 1;
            if (n > 4) begin
                abort_run("pixel clock enable stopped toggling");
            end
            @(posedge clk);
        end
    endtask

    task automatic init_inputs();
        rst      <= 1'b1;
        video_en <= 1'b0;
        pre_lhbl <= 1'b0;   // Idle pixels are blanked
        pre_lvbl <= 1'b0;
        pal_cs   <= 1'b0;
        cpu_addr <= '0;
        cpu_dout <= '0;
        dswn     <= 2'b11;  // No byte strobes
        pal_addr <= '0;
        shadow   <= 1'b0;
    endtask

    task automatic apply_reset();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Byte strobes low active, model follows only selected bytes
    task automatic cpu_write(input colmix_pkg::cpu_addr_t a, input colmix_pkg::pal_word_t d,
                             input logic [1:0] ds, input logic cs);
        colmix_pkg::pal_addr_t idx;
        idx = a[colmix_pkg::PAL_AW-1:0];  // Mirrors fold down
        @(posedge clk);
        pal_cs   <= cs;
        cpu_addr <= a;
        cpu_dout <= d;
        dswn     <= ds;
        @(posedge clk);  // Write lands here
        pal_cs <= 1'b0;
        dswn   <= 2'b11;
        if (cs && !ds[0]) begin
            pal_model[idx][7:0] = d[7:0];
        end
        if (cs && !ds[1]) begin
            pal_model[idx][15:8] = d[15:8];
        end
    endtask

    task automatic cpu_read_check(input string name, input colmix_pkg::cpu_addr_t a);
        @(posedge clk);
        cpu_addr <= a;
        @(posedge clk);  // Read data registered
        @(negedge clk);
        check_eq(name, 32'(pal_model[a[colmix_pkg::PAL_AW-1:0]]), 32'(cpu_din));
    endtask

    // Output expected for one request, from the palette word layout
    function automatic logic [16:0] expect_px(input colmix_pkg::pal_word_t w, input logic sh,
                                              input logic ven, input logic hb, input logic vb);
        colmix_pkg::chan_t r;
        colmix_pkg::chan_t g;
        colmix_pkg::chan_t b;
        r = {w[3:0], w[12]};
        g = {w[7:4], w[13]};
        b = {w[11:8], w[14]};
        if (sh && !w[15]) begin  // Three quarters unless immune
            r = r - (r >> 2);
            g = g - (g >> 2);
            b = b - (b >> 2);
        end
        if (!ven || !hb || !vb) begin
            r = '0;
            g = '0;
            b = '0;
        end
        return {hb, vb, r, g, b};
    endfunction

    // Two pixels already in flight, checked only when known
    task automatic flush_pipe(input logic known_zero);
        exp_q.delete();
        exp_q.push_back({known_zero, 17'h0});
        exp_q.push_back({known_zero, 17'h0});
    endtask

    // One pixel per strobe, output of two strobes back checked
    task automatic drive_pixel(input string name, input colmix_pkg::pal_addr_t a,
                               input logic sh, input logic ven, input logic hb, input logic vb);
        logic [17:0] e;
        logic [16:0] act;
        wait_cen(1'b0);
        pal_addr <= a;
        shadow   <= sh;
        video_en <= ven;
        pre_lhbl <= hb;
        pre_lvbl <= vb;
        exp_q.push_back({1'b1, expect_px(pal_model[a], sh, ven, hb, vb)});
        wait_cen(1'b1);  // Sampled here
        @(negedge clk);
        act = {lhbl, lvbl, red, green, blue};
        e = exp_q.pop_front();
        if (e[17]) begin
            check_eq(name, 32'(e[16:0]), 32'(act));
        end
    endtask

    task automatic drain_pipe(input string name);
        drive_pixel(name, pix_addr[0], 1'b0, 1'b0, 1'b0, 1'b0);
        drive_pixel(name, pix_addr[0], 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic load_entries(input logic mix_immune);
        int ra;
        int rw;
        colmix_pkg::pal_word_t w;
        for (int i = 0; i < 16; i++) begin
            ra = $random(seed);
            rw = $random(seed);
            w = rw[15:0];
            if (mix_immune) begin
                w[15] = i[0];  // Alternate immune entries
            end
            pix_addr[i] = ra[10:0];
            cpu_write(ra[12:0], w, 2'b00, 1'b1);  // Random mirror bits too
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_eq("reset", 32'h0, 32'({lhbl, lvbl, red, green, blue}));
        flush_pipe(1'b1);  // Cleared stages hold blanked pixels
        for (int i = 0; i < 3; i++) begin
            drive_pixel("reset", pix_addr[0], 1'b0, 1'b0, 1'b1, 1'b1);
        end
        drain_pipe("reset drain");
    endtask

    task automatic test_cpu_port();
        cpu_write(13'h0010, 16'h1234, 2'b00, 1'b1);
        cpu_read_check("cpu word", 13'h0010);
        cpu_write(13'h07ff, 16'habcd, 2'b00, 1'b1);
        cpu_read_check("cpu word top", 13'h07ff);
        cpu_write(13'h0010, 16'hff55, 2'b10, 1'b1);  // Low byte only
        cpu_read_check("cpu low byte", 13'h0010);
        cpu_write(13'h0010, 16'h99ee, 2'b01, 1'b1);  // High byte only
        cpu_read_check("cpu high byte", 13'h0010);
        check_eq("cpu byte merge", 32'h9955, 32'(cpu_din));
        cpu_write(13'h0010, 16'h0000, 2'b00, 1'b0);  // Strobes without select
        cpu_read_check("cpu no select", 13'h0010);
        cpu_write(13'h1805, 16'h5a5a, 2'b00, 1'b1);
        cpu_read_check("cpu mirror base", 13'h0005);
        cpu_read_check("cpu mirror mid", 13'h0805);
    endtask

    task automatic test_unpack();
        load_entries(1'b0);
        flush_pipe(1'b0);
        for (int i = 0; i < 16; i++) begin
            drive_pixel("unpack", pix_addr[i], 1'b0, 1'b1, 1'b1, 1'b1);
        end
        drain_pipe("unpack drain");
    endtask

    task automatic test_shadow();
        load_entries(1'b1);
        cpu_write(13'h07f0, 16'h7fff, 2'b00, 1'b1);  // Full white, dims to 24
        cpu_write(13'h07f1, 16'hffff, 2'b00, 1'b1);  // Immune white
        flush_pipe(1'b0);
        for (int i = 0; i < 16; i++) begin
            drive_pixel("shadow", pix_addr[i], 1'b1, 1'b1, 1'b1, 1'b1);
        end
        drive_pixel("shadow white", 11'h7f0, 1'b1, 1'b1, 1'b1, 1'b1);
        drive_pixel("shadow immune", 11'h7f1, 1'b1, 1'b1, 1'b1, 1'b1);
        drive_pixel("shadow off", 11'h7f0, 1'b0, 1'b1, 1'b1, 1'b1);
        drain_pipe("shadow drain");
    endtask

    task automatic test_video_en();
        flush_pipe(1'b0);
        for (int i = 0; i < 16; i++) begin
            drive_pixel("video_en", pix_addr[i], i[0], 1'b0, 1'b1, 1'b1);
        end
        drain_pipe("video_en drain");
    endtask

    task automatic test_blanking();
        logic bl;
        flush_pipe(1'b0);
        for (int i = 0; i < 12; i++) begin
            bl = (i >= 4 && i <= 6);  // Short horizontal blank
            drive_pixel("hblank", pix_addr[i], 1'b0, 1'b1, !bl, 1'b1);
        end
        for (int i = 0; i < 12; i++) begin
            bl = (i == 3 || i == 8);  // Single pixel vertical blanks
            drive_pixel("vblank", pix_addr[i], i[1], 1'b1, 1'b1, !bl);
        end
        drain_pipe("blank drain");
    endtask

    initial begin
        init_inputs();
        apply_reset();
        test_reset();
        test_cpu_port();
        test_unpack();
        test_shadow();
        test_video_en();
        test_blanking();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
